// ==== flist.f ====
+incdir+verilog
verilog/lsu_pkg.sv
verilog/lsu_decode.sv
verilog/lsu_axi_master.sv
verilog/lsu_clint.sv
verilog/lsu_load_result.sv
verilog/lsu_top.sv
test/tb_axi_mem.sv
test/tb_lsu.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f flist.f --top-module tb_lsu

status=0
./obj_dir/Vtb_lsu > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

// ==== test/tb_lsu.sv ====
`timescale 1ns/100ps
`include "lsu_macros.svh"

module tb_lsu;
    import lsu_pkg::*;

    // worst case about 12 cycles per request
    localparam int    N_REQ      = 200;
    localparam int    MAX_CYCLES = N_REQ * 12 + 100;
    localparam int    MEM_WORDS  = 32;
    localparam int    MTIME_GAP  = 20;
    localparam addr_t MEM_BASE   = 32'h0000_0100;
    localparam addr_t MTIME_LO   = `LSU_CLINT_BASE + {`LSU_MTIME_LO_OFS, 2'b00};

    logic     clk;
    logic     rst_n;
    logic     req_valid, req_ready;
    lsu_req_t req;
    logic     rsp_valid;
    lsu_rsp_t rsp;
    logic     ar_valid, ar_ready;
    axi_ar_t  ar;
    logic     aw_valid, aw_ready;
    axi_aw_t  aw;
    logic     w_valid, w_ready;
    axi_w_t   w;
    logic     r_valid, r_ready;
    axi_r_t   r;
    logic     b_valid, b_ready;
    axi_b_t   b;

    // mirror of the tested memory region
    logic [7:0] ref_mem [0:MEM_WORDS*4-1];
    data_t      exp_rdata;
    logic       exp_err;
    logic       chk_rdata;
    strb_t      exp_strb;
    addr_t      exp_addr;
    axi_size_t  exp_size;
    logic       clint_op;
    logic       started;
    int         outstanding;
    int         cycles;
    int         n_rsp;
    int         n_issued;
    int         n_value_err;
    int         n_proto_err;
    data_t      mtime_0, mtime_1;

    lsu_top i_lsu_top (.*);
    tb_axi_mem i_axi_mem (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout, test still running after %0d cycles", MAX_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (req_valid && req_ready) outstanding <= outstanding + 1;
        if (rsp_valid) begin
            outstanding <= outstanding - 1;
            n_rsp       <= n_rsp + 1;
        end
    end

    a_reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> req_ready && !rsp_valid && !ar_valid && !aw_valid && !w_valid &&
                     !r_ready && !b_ready)
        else begin
            n_proto_err++;
            $display("%0t: LSU not idle after reset before the first request", $time);
        end

    a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && chk_rdata |-> rsp.rdata == exp_rdata)
        else begin
            n_value_err++;
            $display("ERR %0t rsp.rdata expected %h got %h",
                     $time, $sampled(exp_rdata), $sampled(rsp.rdata));
        end

    a_err: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> rsp.err == exp_err)
        else begin
            n_value_err++;
            $display("ERR %0t rsp.err expected %b got %b",
                     $time, $sampled(exp_err), $sampled(rsp.err));
        end

    a_strb: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid |-> w.strb == exp_strb)
        else begin
            n_value_err++;
            $display("ERR %0t w.strb expected %b got %b",
                     $time, $sampled(exp_strb), $sampled(w.strb));
        end

    a_ar_pay: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid |-> ar.addr == exp_addr && ar.size == exp_size)
        else begin
            n_value_err++;
            $display("ERR %0t ar expected %h size %0d got %h size %0d", $time,
                     $sampled(exp_addr), $sampled(exp_size),
                     $sampled(ar.addr), $sampled(ar.size));
        end

    a_aw_pay: assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid |-> aw.addr == exp_addr && aw.size == exp_size)
        else begin
            n_value_err++;
            $display("ERR %0t aw expected %h size %0d got %h size %0d", $time,
                     $sampled(exp_addr), $sampled(exp_size),
                     $sampled(aw.addr), $sampled(aw.size));
        end

    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
        else begin
            n_proto_err++;
            $display("%0t: ar_valid or ar changed before ar_ready", $time);
        end

    a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else begin
            n_proto_err++;
            $display("%0t: aw_valid or aw changed before aw_ready", $time);
        end

    a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid && !w_ready |=> w_valid && $stable(w))
        else begin
            n_proto_err++;
            $display("%0t: w_valid or w changed before w_ready", $time);
        end

    a_clint_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        clint_op |-> !ar_valid && !aw_valid && !w_valid)
        else begin
            n_proto_err++;
            $display("%0t: bus valid raised during a timer access", $time);
        end

    a_one_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        (!rsp_valid || outstanding == 1) && (!(req_valid && req_ready) || outstanding == 0))
        else begin
            n_proto_err++;
            $display("%0t: request accepted before the previous response", $time);
        end

    function automatic strb_t lane_strobe(input logic [1:0] lo, input lsu_width_e wid);
        strb_t mask;
        case (wid)
            width_byte: mask = 4'b0001;
            width_half: mask = 4'b0011;
            default:    mask = 4'b1111;
        endcase
        return mask << lo;
    endfunction

    // log2 of the bytes moved
    function automatic axi_size_t access_size(input lsu_width_e wid);
        case (wid)
            width_byte: return 3'd0;
            width_half: return 3'd1;
            default:    return 3'd2;
        endcase
    endfunction

    // reference bytes, then zero or sign fill from the top kept bit
    function automatic data_t load_expect(input int unsigned ofs, input lsu_width_e wid,
                                          input logic sg);
        data_t v;
        case (wid)
            width_byte: begin
                v = {24'd0, ref_mem[ofs]};
                if (sg && v[7]) v[31:8] = '1;
            end
            width_half: begin
                v = {16'd0, ref_mem[ofs+1], ref_mem[ofs]};
                if (sg && v[15]) v[31:16] = '1;
            end
            default: v = {ref_mem[ofs+3], ref_mem[ofs+2], ref_mem[ofs+1], ref_mem[ofs]};
        endcase
        return v;
    endfunction

    function automatic int unsigned pick_offset(input lsu_width_e wid);
        int unsigned base;
        base = ($urandom % MEM_WORDS) * 4;
        case (wid)
            width_byte: return base + ($urandom % 4);
            width_half: return base + ($urandom % 2) * 2;
            default:    return base;
        endcase
    endfunction

    // one request, back once its response pulse is seen
    task automatic run_req(input addr_t a, input data_t wd, input logic wr,
                           input lsu_width_e wid, input logic sg);
        req_valid <= 1'b1;
        req       <= '{addr: a, wdata: wd, is_write: wr, width: wid, sign: sg};
        do @(posedge clk); while (!req_ready);
        req_valid <= 1'b0;
        n_issued++;
        do @(posedge clk); while (!rsp_valid);
    endtask

    task automatic mem_store(input int unsigned ofs, input lsu_width_e wid, input data_t wd);
        int nbytes;
        nbytes    = (wid == width_byte) ? 1 : (wid == width_half) ? 2 : 4;
        exp_err   <= 1'b0;
        chk_rdata <= 1'b0;
        clint_op  <= 1'b0;
        exp_strb  <= lane_strobe(ofs[1:0], wid);
        exp_addr  <= MEM_BASE + ofs;
        exp_size  <= access_size(wid);
        for (int k = 0; k < nbytes; k++) ref_mem[ofs+k] = wd[8*k +: 8];
        run_req(MEM_BASE + ofs, wd, 1'b1, wid, 1'b0);
    endtask

    task automatic mem_load(input int unsigned ofs, input lsu_width_e wid, input logic sg);
        exp_rdata <= load_expect(ofs, wid, sg);
        exp_err   <= 1'b0;
        chk_rdata <= 1'b1;
        clint_op  <= 1'b0;
        exp_addr  <= MEM_BASE + ofs;
        exp_size  <= access_size(wid);
        run_req(MEM_BASE + ofs, '0, 1'b0, wid, sg);
    endtask

    task automatic clint_access(input logic wr, output data_t val);
        exp_err   <= wr;
        chk_rdata <= 1'b0;
        clint_op  <= 1'b1;
        run_req(MTIME_LO, 32'h1234_5678, wr, width_word, 1'b0);
        val = rsp.rdata;
    endtask

    initial begin
        int unsigned ofs;
        lsu_width_e  wid;
        data_t       dummy;
        void'($urandom(32'hb637_b215));
        rst_n     <= 1'b0;
        req_valid <= 1'b0;
        req       <= '0;
        exp_rdata <= '0;
        exp_err   <= 1'b0;
        chk_rdata <= 1'b0;
        exp_strb  <= '0;
        exp_addr  <= '0;
        exp_size  <= '0;
        clint_op  <= 1'b0;
        started   <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        // idle outputs checked over these cycles
        repeat (3) @(posedge clk);
        started <= 1'b1;
        for (int i = 0; i < MEM_WORDS; i++) mem_store(i * 4, width_word, $urandom);
        for (int n = 0; n < 60; n++) begin
            wid = lsu_width_e'(2'($urandom % 3));
            ofs = pick_offset(wid);
            mem_store(ofs, wid, $urandom);
            mem_load(ofs, wid, 1'($urandom % 2));
        end
        for (int n = 0; n < 20; n++) begin
            wid = lsu_width_e'(2'($urandom % 3));
            mem_load(pick_offset(wid), wid, 1'($urandom % 2));
        end
        clint_access(1'b0, mtime_0);
        clint_op <= 1'b0;
        repeat (MTIME_GAP) @(posedge clk);
        clint_access(1'b0, mtime_1);
        a_mtime: assert (mtime_1 - mtime_0 >= data_t'(MTIME_GAP))
            else begin
                n_value_err++;
                $display("ERR %0t mtime delta expected >= %0d got %0d",
                         $time, MTIME_GAP, mtime_1 - mtime_0);
            end
        clint_access(1'b1, dummy);
        mem_load(0, width_word, 1'b0);
        repeat (2) @(posedge clk);
        if (n_rsp != n_issued) begin
            n_proto_err++;
            $display("%0d requests issued but %0d responses seen", n_issued, n_rsp);
        end
        $display("responses %0d, value errors %0d, protocol errors %0d",
                 n_rsp, n_value_err, n_proto_err);
        if (n_value_err + n_proto_err == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== test/tb_axi_mem.sv ====
`timescale 1ns/100ps

module tb_axi_mem (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             ar_valid,
    output logic             ar_ready,
    input  lsu_pkg::axi_ar_t ar,
    input  logic             aw_valid,
    output logic             aw_ready,
    input  lsu_pkg::axi_aw_t aw,
    input  logic             w_valid,
    output logic             w_ready,
    input  lsu_pkg::axi_w_t  w,
    output logic             r_valid,
    input  logic             r_ready,
    output lsu_pkg::axi_r_t  r,
    output logic             b_valid,
    input  logic             b_ready,
    output lsu_pkg::axi_b_t  b
);
    import lsu_pkg::*;

    // 1 KiB, byte wide
    logic [7:0] mem [0:1023];
    logic [1:0] ar_cnt, aw_cnt, w_cnt, r_cnt, b_cnt;
    logic       r_pend, b_pend, aw_got, w_got;
    addr_t      rd_addr, wr_addr;
    axi_w_t     w_q;

    function automatic logic [1:0] pick_delay();
        return 2'($urandom % 4);
    endfunction

    function automatic data_t read_word(input addr_t a);
        return {mem[{a[9:2], 2'd3}], mem[{a[9:2], 2'd2}],
                mem[{a[9:2], 2'd1}], mem[{a[9:2], 2'd0}]};
    endfunction

    // ready is high once the random wait after the last handshake runs out
    assign ar_ready = (ar_cnt == 2'd0);
    assign aw_ready = (aw_cnt == 2'd0);
    assign w_ready  = (w_cnt == 2'd0);
    assign b        = '{resp: 2'b00};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_cnt <= 2'd0;
            aw_cnt <= 2'd0;
            w_cnt  <= 2'd0;
        end else begin
            if (ar_valid && ar_ready) ar_cnt <= pick_delay();
            else if (ar_cnt != 2'd0) ar_cnt <= ar_cnt - 2'd1;
            if (aw_valid && aw_ready) aw_cnt <= pick_delay();
            else if (aw_cnt != 2'd0) aw_cnt <= aw_cnt - 2'd1;
            if (w_valid && w_ready) w_cnt <= pick_delay();
            else if (w_cnt != 2'd0) w_cnt <= w_cnt - 2'd1;
        end
    end

    // read data after a random wait, held until taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_valid <= 1'b0;
            r_pend  <= 1'b0;
            r_cnt   <= 2'd0;
        end else begin
            if (ar_valid && ar_ready) begin
                rd_addr <= ar.addr;
                r_pend  <= 1'b1;
                r_cnt   <= pick_delay();
            end else if (r_pend && r_cnt != 2'd0) begin
                r_cnt <= r_cnt - 2'd1;
            end else if (r_pend) begin
                r_pend  <= 1'b0;
                r_valid <= 1'b1;
                r       <= '{data: read_word(rd_addr), resp: 2'b00};
            end
            if (r_valid && r_ready) r_valid <= 1'b0;
        end
    end

    // aw and w in either order, memory written once both are in
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            b_pend  <= 1'b0;
            b_valid <= 1'b0;
            b_cnt   <= 2'd0;
            // fill pattern over the whole address
            for (int i = 0; i < 1024; i++) begin
                mem[i] <= 8'(i) ^ 8'(i >> 3) ^ 8'h5a;
            end
        end else begin
            if (aw_valid && aw_ready) begin
                wr_addr <= aw.addr;
                aw_got  <= 1'b1;
            end
            if (w_valid && w_ready) begin
                w_q   <= w;
                w_got <= 1'b1;
            end
            if (aw_got && w_got) begin
                for (int k = 0; k < 4; k++) begin
                    if (w_q.strb[k]) mem[{wr_addr[9:2], k[1:0]}] <= w_q.data[8*k +: 8];
                end
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                b_pend <= 1'b1;
                b_cnt  <= pick_delay();
            end else if (b_pend && b_cnt != 2'd0) begin
                b_cnt <= b_cnt - 2'd1;
            end else if (b_pend) begin
                b_pend  <= 1'b0;
                b_valid <= 1'b1;
            end
            if (b_valid && b_ready) b_valid <= 1'b0;
        end
    end

endmodule

// ==== verilog/lsu_top.sv ====
`timescale 1ns/100ps

module lsu_top (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              req_valid,
    output logic              req_ready,
    input  lsu_pkg::lsu_req_t req,
    output logic              rsp_valid,
    output lsu_pkg::lsu_rsp_t rsp,

    output logic              ar_valid,
    input  logic              ar_ready,
    output lsu_pkg::axi_ar_t  ar,
    output logic              aw_valid,
    input  logic              aw_ready,
    output lsu_pkg::axi_aw_t  aw,
    output logic              w_valid,
    input  logic              w_ready,
    output lsu_pkg::axi_w_t   w,
    input  logic              r_valid,
    output logic              r_ready,
    input  lsu_pkg::axi_r_t   r,
    input  logic              b_valid,
    output logic              b_ready,
    input  lsu_pkg::axi_b_t   b
);
    import lsu_pkg::*;

    lsu_access_t access;

    // execute to timer
    logic        clint_arvalid;
    logic        clint_arready;
    addr_t       clint_araddr;
    logic        clint_rvalid;
    logic        clint_rready;
    axi_r_t      clint_r;

    // execute to result stage
    data_t       rdata_raw;
    logic        exe_err;
    logic [1:0]  low_addr;
    lsu_width_e  width;
    logic        sign;
    data_t       rdata;

    lsu_decode i_decode (
        .req    (req),
        .access (access)
    );

    lsu_axi_master i_axi_master (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .access        (access),
        .req_ready     (req_ready),
        .ar_valid      (ar_valid),
        .ar_ready      (ar_ready),
        .ar            (ar),
        .aw_valid      (aw_valid),
        .aw_ready      (aw_ready),
        .aw            (aw),
        .w_valid       (w_valid),
        .w_ready       (w_ready),
        .w             (w),
        .r_valid       (r_valid),
        .r_ready       (r_ready),
        .r             (r),
        .b_valid       (b_valid),
        .b_ready       (b_ready),
        .b             (b),
        .clint_arvalid (clint_arvalid),
        .clint_arready (clint_arready),
        .clint_araddr  (clint_araddr),
        .clint_rvalid  (clint_rvalid),
        .clint_rready  (clint_rready),
        .clint_r       (clint_r),
        .rsp_valid     (rsp_valid),
        .rdata_raw     (rdata_raw),
        .err           (exe_err),
        .low_addr      (low_addr),
        .width         (width),
        .sign          (sign)
    );

    lsu_clint i_clint (
        .clk     (clk),
        .rst_n   (rst_n),
        .arvalid (clint_arvalid),
        .arready (clint_arready),
        .araddr  (clint_araddr),
        .rvalid  (clint_rvalid),
        .rready  (clint_rready),
        .r       (clint_r)
    );

    lsu_load_result i_load_result (
        .rdata_raw (rdata_raw),
        .low_addr  (low_addr),
        .width     (width),
        .sign      (sign),
        .rdata     (rdata)
    );

    assign rsp = '{rdata: rdata, err: exe_err};

endmodule

// ==== verilog/lsu_load_result.sv ====
`timescale 1ns/100ps

module lsu_load_result (
    input  lsu_pkg::data_t      rdata_raw,
    input  logic [1:0]          low_addr,
    input  lsu_pkg::lsu_width_e width,
    input  logic                sign,
    output lsu_pkg::data_t      rdata
);
    import lsu_pkg::*;

    data_t shifted;

    // bring the addressed lane down to bit 0
    assign shifted = rdata_raw >> {low_addr, 3'b000};

    always_comb begin
        case (width)
            width_byte: begin
                rdata = {{24{sign & shifted[7]}}, shifted[7:0]};
            end
            width_half: begin
                rdata = {{16{sign & shifted[15]}}, shifted[15:0]};
            end
            default: begin
                rdata = shifted;
            end
        endcase
    end

endmodule

// ==== verilog/lsu_clint.sv ====
`timescale 1ns/100ps
`include "lsu_macros.svh"

module lsu_clint (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            arvalid,
    output logic            arready,
    input  lsu_pkg::addr_t  araddr,
    output logic            rvalid,
    input  logic            rready,
    output lsu_pkg::axi_r_t r
);
    import lsu_pkg::*;

    logic [63:0] mtime;
    addr_t       ofs;
    data_t       rdata_q;

    // single outstanding read, so always ready
    assign arready = 1'b1;
    assign ofs     = araddr - `LSU_CLINT_BASE;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else begin
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (arvalid && arready) begin
                rvalid <= 1'b1;
            end
        end
    end

    // snapshot of the addressed half
    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            if (ofs[31:2] == `LSU_MTIME_LO_OFS) begin
                rdata_q <= mtime[31:0];
            end else if (ofs[31:2] == `LSU_MTIME_HI_OFS) begin
                rdata_q <= mtime[63:32];
            end else begin
                rdata_q <= '0;
            end
        end
    end

    // okay response on every read
    assign r = '{data: rdata_q, resp: 2'b00};

    a_rvalid_after_ar: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rvalid) |-> $past(arvalid && arready))
        else $error("rvalid raised without an accepted read");

endmodule

// ==== verilog/lsu_axi_master.sv ====
`timescale 1ns/100ps

module lsu_axi_master (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    input  lsu_pkg::lsu_access_t access,
    output logic                 req_ready,

    output logic                 ar_valid,
    input  logic                 ar_ready,
    output lsu_pkg::axi_ar_t     ar,
    output logic                 aw_valid,
    input  logic                 aw_ready,
    output lsu_pkg::axi_aw_t     aw,
    output logic                 w_valid,
    input  logic                 w_ready,
    output lsu_pkg::axi_w_t      w,
    input  logic                 r_valid,
    output logic                 r_ready,
    input  lsu_pkg::axi_r_t      r,
    input  logic                 b_valid,
    output logic                 b_ready,
    input  lsu_pkg::axi_b_t      b,

    output logic                 clint_arvalid,
    input  logic                 clint_arready,
    output lsu_pkg::addr_t       clint_araddr,
    input  logic                 clint_rvalid,
    output logic                 clint_rready,
    input  lsu_pkg::axi_r_t      clint_r,

    output logic                 rsp_valid,
    output lsu_pkg::data_t       rdata_raw,
    output logic                 err,
    output logic [1:0]           low_addr,
    output lsu_pkg::lsu_width_e  width,
    output logic                 sign
);
    import lsu_pkg::*;

    lsu_state_e  state;
    lsu_access_t acc;
    logic        aw_done;
    logic        w_done;
    data_t       rdata_q;
    logic        err_q;
    logic        bus_rd;
    logic        bus_wr;
    logic        clint_rd;
    logic        aw_ok;
    logic        w_ok;
    logic        ar_hs;
    logic        r_hs;
    axi_r_t      rd_beat;

    assign bus_rd   = !acc.is_write && !acc.is_clint;
    assign bus_wr   = acc.is_write && !acc.is_clint;
    assign clint_rd = !acc.is_write && acc.is_clint;

    assign req_ready     = (state == st_idle);
    assign rsp_valid     = (state == st_done);
    assign ar_valid      = (state == st_addr) && bus_rd;
    assign clint_arvalid = (state == st_addr) && clint_rd;
    assign aw_valid      = (state == st_addr) && bus_wr && !aw_done;
    assign w_valid       = (state == st_addr) && bus_wr && !w_done;
    assign r_ready       = (state == st_data) && bus_rd;
    assign clint_rready  = (state == st_data) && clint_rd;
    assign b_ready       = (state == st_resp);

    // payloads come straight from the held access
    assign ar           = '{addr: acc.addr, size: acc.size};
    assign aw           = '{addr: acc.addr, size: acc.size};
    assign w            = '{data: acc.wdata, strb: acc.strb};
    assign clint_araddr = acc.addr;

    // aw and w may be taken in either order
    assign aw_ok   = aw_done || (aw_valid && aw_ready);
    assign w_ok    = w_done || (w_valid && w_ready);
    assign ar_hs   = (ar_valid && ar_ready) || (clint_arvalid && clint_arready);
    assign r_hs    = (r_valid && r_ready) || (clint_rvalid && clint_rready);
    assign rd_beat = acc.is_clint ? clint_r : r;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (req_valid) begin
                        // timer window is read only, finish at once
                        if (access.is_write && access.is_clint) begin
                            state <= st_done;
                        end else begin
                            state <= st_addr;
                        end
                    end
                end
                st_addr: begin
                    if (acc.is_write) begin
                        if (aw_ok && w_ok) begin
                            state   <= st_resp;
                            aw_done <= 1'b0;
                            w_done  <= 1'b0;
                        end else begin
                            aw_done <= aw_ok;
                            w_done  <= w_ok;
                        end
                    end else if (ar_hs) begin
                        state <= st_data;
                    end
                end
                st_data: begin
                    if (r_hs) begin
                        state <= st_done;
                    end
                end
                st_resp: begin
                    if (b_valid) begin
                        state <= st_done;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            acc     <= access;
            rdata_q <= '0;
            err_q   <= access.is_write && access.is_clint;
        end
        if (r_hs) begin
            rdata_q <= rd_beat.data;
            err_q   <= (rd_beat.resp != 2'b00);
        end
        if (b_valid && b_ready) begin
            err_q <= (b.resp != 2'b00);
        end
    end

    assign rdata_raw = rdata_q;
    assign err       = err_q;
    assign low_addr  = acc.low_addr;
    assign width     = acc.width;
    assign sign      = acc.sign;

    // read address held with a stable payload until taken
    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
        else $error("ar_valid dropped or ar changed before ar_ready");

    // only one address channel in use at a time
    a_one_addr: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({ar_valid, aw_valid, clint_arvalid}))
        else $error("more than one address valid raised");

endmodule

// ==== verilog/lsu_decode.sv ====
`timescale 1ns/100ps
`include "lsu_macros.svh"

module lsu_decode (
    input  lsu_pkg::lsu_req_t    req,
    output lsu_pkg::lsu_access_t access
);
    import lsu_pkg::*;

    strb_t     strb;
    axi_size_t size;
    logic      in_clint;

    // lane select from width and low address bits
    always_comb begin
        case (req.width)
            width_byte: begin
                strb = 4'b0001 << req.addr[1:0];
                size = 3'd0;
            end
            width_half: begin
                strb = req.addr[1] ? 4'b1100 : 4'b0011;
                size = 3'd1;
            end
            default: begin
                strb = 4'b1111;
                size = 3'd2;
            end
        endcase
    end

    assign in_clint = (req.addr >= `LSU_CLINT_BASE) && (req.addr <= `LSU_CLINT_END);

    assign access.addr     = req.addr;
    // move write data up into the addressed lanes
    assign access.wdata    = req.wdata << {req.addr[1:0], 3'b000};
    assign access.strb     = strb;
    assign access.size     = size;
    assign access.is_write = req.is_write;
    assign access.is_clint = in_clint;
    assign access.width    = req.width;
    assign access.sign     = req.sign;
    assign access.low_addr = req.addr[1:0];

    // no access may cross a word boundary
    always_comb begin
        if (!$isunknown(req.width)) begin
            a_align: assert ((req.width != width_half || !req.addr[0]) &&
                             (req.width != width_word || req.addr[1:0] == 2'b00))
                else $error("misaligned access, width %0d addr %h", req.width, req.addr);
        end
    end

endmodule

// ==== verilog/lsu_pkg.sv ====
package lsu_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    // log2 of bytes per beat
    typedef logic [2:0]  axi_size_t;

    typedef enum logic [1:0] {
        width_byte,
        width_half,
        width_word
    } lsu_width_e;

    typedef enum logic [2:0] {
        st_idle,
        st_addr,
        st_data,
        st_resp,
        st_done
    } lsu_state_e;

    typedef struct packed {
        addr_t      addr;
        data_t      wdata;
        logic       is_write;
        lsu_width_e width;
        logic       sign;
    } lsu_req_t;

    // request after decode, wdata already in its byte lanes
    typedef struct packed {
        addr_t      addr;
        data_t      wdata;
        strb_t      strb;
        axi_size_t  size;
        logic       is_write;
        logic       is_clint;
        lsu_width_e width;
        logic       sign;
        logic [1:0] low_addr;
    } lsu_access_t;

    typedef struct packed {
        data_t rdata;
        logic  err;
    } lsu_rsp_t;

    typedef struct packed {
        addr_t     addr;
        axi_size_t size;
    } axi_ar_t;

    typedef struct packed {
        addr_t     addr;
        axi_size_t size;
    } axi_aw_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } axi_w_t;

    typedef struct packed {
        data_t      data;
        logic [1:0] resp;
    } axi_r_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

endpackage

// ==== verilog/lsu_macros.svh ====
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// core-local timer window, inclusive byte range of 8 bytes
`define LSU_CLINT_BASE (32'ha000_0048)
`define LSU_CLINT_END  (32'ha000_004f)

// mtime halves as word index from the window base
`define LSU_MTIME_LO_OFS (30'd0)
`define LSU_MTIME_HI_OFS (30'd1)

`endif
